// ==== src/ace_kbd_pkg.sv ====
`default_nettype none

package ace_kbd_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Host matrix geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int num_rows = 8;
    localparam int num_cols = 5;

    typedef logic [2:0] row_t;
    typedef logic [2:0] col_t;

    ////////////////////////////////////////////////////////////////////////////
    // PS/2 set 2 codes
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [7:0] prefix_ext = 8'he0;  // Extended key follows
    localparam logic [7:0] prefix_brk = 8'hf0;  // Key release follows

    // Right control and the cursor keys share these codes, told apart by E0
    typedef enum logic [7:0] {
        key_a = 8'h1c, key_b = 8'h32, key_c = 8'h21, key_d = 8'h23,
        key_e = 8'h24, key_f = 8'h2b, key_g = 8'h34, key_h = 8'h33,
        key_i = 8'h43, key_j = 8'h3b, key_k = 8'h42, key_l = 8'h4b,
        key_m = 8'h3a, key_n = 8'h31, key_o = 8'h44, key_p = 8'h4d,
        key_q = 8'h15, key_r = 8'h2d, key_s = 8'h1b, key_t = 8'h2c,
        key_u = 8'h3c, key_v = 8'h2a, key_w = 8'h1d, key_x = 8'h22,
        key_y = 8'h35, key_z = 8'h1a,
        key_0 = 8'h45, key_1 = 8'h16, key_2 = 8'h1e, key_3 = 8'h26,
        key_4 = 8'h25, key_5 = 8'h2e, key_6 = 8'h36, key_7 = 8'h3d,
        key_8 = 8'h3e, key_9 = 8'h46,
        key_space = 8'h29,
        key_enter = 8'h5a,
        key_esc = 8'h76,
        key_bksp = 8'h66,
        key_caps = 8'h58,
        key_f2 = 8'h06,
        key_f5 = 8'h03,
        key_lshift = 8'h12,
        key_rshift = 8'h59,
        key_ctrl = 8'h14,
        key_lalt = 8'h11,
        key_kp_period = 8'h71,
        key_up = 8'h75,     // Keypad 8 without E0
        key_down = 8'h72,
        key_left = 8'h6b,
        key_right = 8'h74
    } key_code_t;

    ////////////////////////////////////////////////////////////////////////////
    // Prefix tracking
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        idle,
        ext_seen,
        brk_seen,
        ext_brk_seen
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== src/ps2_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module ps2_receiver #(
    parameter int FRAME_TIMEOUT = 2000
) (
    input wire clk,
    input wire rst_n,
    input wire clkps2,
    input wire dataps2,
    output logic byte_valid,
    output logic [7:0] rx_byte
);

    localparam int idle_w = $clog2(FRAME_TIMEOUT + 1);

    logic [2:0] clk_sync;       // Two sync stages plus edge history
    logic [1:0] data_sync;
    logic fall;
    logic [9:0] frame;
    logic [10:0] frame_next;
    logic frame_ok;
    logic [3:0] bit_cnt;
    logic [idle_w-1:0] idle_cnt;

    assign fall = clk_sync[2] && !clk_sync[1];
    assign frame_next = {data_sync[1], frame};

    // Start low, odd parity over data and parity, stop high
    assign frame_ok = !frame_next[0] && (^frame_next[9:1]) && frame_next[10];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            clk_sync <= '1;     // Bus idles high
            data_sync <= '1;
        end
        else
        begin
            clk_sync <= {clk_sync[1:0], clkps2};
            data_sync <= {data_sync[0], dataps2};
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            bit_cnt <= '0;
            idle_cnt <= '0;
            byte_valid <= 1'b0;
        end
        else
        begin
            byte_valid <= 1'b0;
            if (fall)
            begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10)
                begin
                    bit_cnt <= '0;
                    byte_valid <= frame_ok;     // Bad frames dropped silently
                end
                else
                    bit_cnt <= bit_cnt + 4'd1;
            end
            else if (bit_cnt != 4'd0)
            begin
                // Line went quiet in mid frame
                if (idle_cnt == idle_w'(FRAME_TIMEOUT - 1))
                begin
                    bit_cnt <= '0;
                    idle_cnt <= '0;
                end
                else
                    idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fall)
        begin
            frame <= frame_next[10:1];
            if (bit_cnt == 4'd10)
                rx_byte <= frame_next[8:1];
        end
    end

endmodule

`default_nettype wire

// ==== src/kbd_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module kbd_controller (
    input wire clk,
    input wire rst_n,
    input wire byte_valid,
    input wire [7:0] rx_byte,
    output logic key_event,
    output ace_kbd_pkg::key_code_t key_code,
    output logic extended,
    output logic released,
    output logic shift,
    output logic ctrl,
    output logic alt,
    output logic clear_all,
    output logic kbd_reset,
    output logic kbd_nmi,
    output logic kbd_mreset
);

    import ace_kbd_pkg::*;

    ctrl_state_t state;
    key_code_t code_in;
    logic ext_now;
    logic brk_now;
    logic combo;

    assign code_in = key_code_t'(rx_byte);
    assign ext_now = (state == ext_seen) || (state == ext_brk_seen);
    assign brk_now = (state == brk_seen) || (state == ext_brk_seen);
    assign combo = ctrl && alt;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= idle;
            key_event <= 1'b0;
            key_code <= key_code_t'(8'h00);
            extended <= 1'b0;
            released <= 1'b0;
            shift <= 1'b0;
            ctrl <= 1'b0;
            alt <= 1'b0;
            clear_all <= 1'b0;
            kbd_reset <= 1'b1;
            kbd_nmi <= 1'b1;
            kbd_mreset <= 1'b1;
        end
        else
        begin
            key_event <= 1'b0;
            clear_all <= 1'b0;
            if (byte_valid)
            begin
                if (rx_byte == prefix_ext)
                    state <= brk_now ? ext_brk_seen : ext_seen;
                else if (rx_byte == prefix_brk)
                    state <= ext_now ? ext_brk_seen : brk_seen;
                else
                begin
                    state <= idle;
                    key_code <= code_in;
                    extended <= ext_now;
                    released <= brk_now;
                    case (code_in)
                        key_lshift, key_rshift:
                            shift <= !brk_now;
                        key_lalt:
                            alt <= !brk_now;
                        key_ctrl:
                        begin
                            ctrl <= !brk_now;   // Also a matrix key
                            key_event <= 1'b1;
                        end
                        // A held line is always let go on release
                        key_f5:
                            if (combo || !kbd_nmi)
                                kbd_nmi <= brk_now;
                            else
                                key_event <= 1'b1;
                        key_kp_period:
                            if (combo || !kbd_reset)
                            begin
                                kbd_reset <= brk_now;
                                clear_all <= !brk_now;
                            end
                            else
                                key_event <= 1'b1;
                        key_bksp:
                            if (combo || !kbd_mreset)
                                kbd_mreset <= brk_now;
                            else
                                key_event <= 1'b1;
                        default:
                            key_event <= 1'b1;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/key_translator.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_translator (
    input wire ace_kbd_pkg::key_code_t key_code,
    input wire extended,
    input wire shift,
    input wire ctrl,
    input wire alt,
    output logic pri_valid,
    output ace_kbd_pkg::row_t pri_row,
    output ace_kbd_pkg::col_t pri_col,
    output logic sec_valid,
    output ace_kbd_pkg::row_t sec_row,
    output ace_kbd_pkg::col_t sec_col
);

    import ace_kbd_pkg::*;

    // Positions as octal {row, col}
    localparam logic [5:0] caps_shift = 6'o00;
    localparam logic [5:0] sym_shift = 6'o01;

    logic [5:0] pri;
    logic [5:0] sec;
    logic pri_on;
    logic use_caps;
    logic use_sym;
    logic is_cursor;

    assign is_cursor = key_code inside {key_up, key_down, key_left, key_right};

    always_comb
    begin
        pri = 6'o00;
        pri_on = 1'b1;
        use_caps = 1'b0;
        use_sym = 1'b0;
        case (key_code)
            key_z: pri = 6'o02;
            key_x: pri = 6'o03;
            key_c: pri = 6'o04;
            key_a: pri = 6'o10;
            key_s: pri = 6'o11;
            key_d: pri = 6'o12;
            key_f: pri = 6'o13;
            key_g: pri = 6'o14;
            key_q: pri = 6'o20;
            key_w: pri = 6'o21;
            key_e: pri = 6'o22;
            key_r: pri = 6'o23;
            key_t: pri = 6'o24;
            key_p: pri = 6'o50;
            key_o: pri = 6'o51;
            key_i: pri = 6'o52;
            key_u: pri = 6'o53;
            key_y: pri = 6'o54;
            key_l: pri = 6'o61;
            key_k: pri = 6'o62;
            key_j: pri = 6'o63;
            key_h: pri = 6'o64;
            key_m: pri = 6'o71;
            key_n: pri = 6'o72;
            key_b: pri = 6'o73;
            key_v: pri = 6'o74;
            key_1: pri = alt ? 6'o11 : 6'o30;                   // alt gives |
            key_2: pri = (shift && !alt) ? 6'o50 : 6'o31;       // alt gives @
            key_3: pri = 6'o32;
            key_4: pri = 6'o33;
            key_5: pri = 6'o34;
            key_6: pri = shift ? 6'o64 : 6'o44;
            key_7: pri = shift ? 6'o44 : 6'o43;
            key_8: pri = shift ? 6'o73 : 6'o42;
            key_9: pri = shift ? 6'o42 : 6'o41;
            key_0: pri = shift ? 6'o41 : 6'o40;
            key_space: pri = 6'o70;
            key_enter: pri = 6'o60;
            key_esc: pri = 6'o70;               // Break
            key_bksp: pri = 6'o40;              // Delete
            key_caps: pri = 6'o31;
            key_f2: pri = 6'o30;                // Edit
            key_up: pri = 6'o44;
            key_down: pri = 6'o43;
            key_left: pri = 6'o34;
            key_right: pri = 6'o42;
            key_ctrl: pri = extended ? sym_shift : caps_shift;
            default: pri_on = 1'b0;
        endcase

        if (key_code inside {key_a, key_b, key_c, key_d, key_e, key_f, key_g, key_h,
                             key_i, key_j, key_k, key_l, key_m, key_n, key_o, key_p,
                             key_q, key_r, key_s, key_t, key_u, key_v, key_w, key_x,
                             key_y, key_z})
            use_caps = shift;
        if (key_code inside {key_0, key_1, key_2, key_3, key_4, key_5, key_6, key_7,
                             key_8, key_9})
            use_sym = shift || (alt && (key_code inside {key_1, key_2}));
        if (key_code inside {key_4, key_9})
            use_caps = ctrl && !shift;  // Inverse video, graphics
        if ((key_code inside {key_esc, key_bksp, key_caps, key_f2}) || is_cursor)
            use_caps = 1'b1;
        if (is_cursor && !extended)
            pri_on = 1'b0;              // Plain keypad digits
    end

    assign sec = use_sym ? sym_shift : caps_shift;

    assign pri_valid = pri_on;
    assign pri_row = pri[5:3];
    assign pri_col = pri[2:0];
    assign sec_valid = pri_on && (use_caps || use_sym);
    assign sec_row = sec[5:3];
    assign sec_col = sec[2:0];

endmodule

`default_nettype wire

// ==== src/key_matrix.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_matrix (
    input wire clk,
    input wire rst_n,
    input wire key_event,
    input wire released,
    input wire clear_all,
    input wire pri_valid,
    input wire ace_kbd_pkg::row_t pri_row,
    input wire ace_kbd_pkg::col_t pri_col,
    input wire sec_valid,
    input wire ace_kbd_pkg::row_t sec_row,
    input wire ace_kbd_pkg::col_t sec_col,
    input wire [ace_kbd_pkg::num_rows-1:0] rows,
    output logic [ace_kbd_pkg::num_cols-1:0] columns
);

    import ace_kbd_pkg::*;

    logic [num_rows-1:0][num_cols-1:0] pressed;     // One bit per key, 1 = down

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pressed <= '0;
        else if (clear_all)
            pressed <= '0;
        else if (key_event)
        begin
            if (pri_valid)
                pressed[pri_row][pri_col] <= !released;
            if (sec_valid)
                pressed[sec_row][sec_col] <= !released;
        end
    end

    // Host drives one or more rows low and reads the columns
    always_comb
    begin
        columns = '1;
        for (int r = 0; r < num_rows; r++)
        begin
            if (!rows[r])
                columns = columns & ~pressed[r];
        end
    end

endmodule

`default_nettype wire

// ==== src/ace_keyboard_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ace_keyboard_top #(
    parameter int FRAME_TIMEOUT = 2000
) (
    input wire clk,
    input wire rst_n,
    input wire clkps2,
    input wire dataps2,
    input wire [ace_kbd_pkg::num_rows-1:0] rows,
    output wire [ace_kbd_pkg::num_cols-1:0] columns,
    output wire kbd_reset,
    output wire kbd_nmi,
    output wire kbd_mreset
);

    import ace_kbd_pkg::*;

    logic byte_valid;
    logic [7:0] rx_byte;
    logic key_event;
    key_code_t key_code;
    logic extended;
    logic released;
    logic shift;
    logic ctrl;
    logic alt;
    logic clear_all;
    logic pri_valid;
    row_t pri_row;
    col_t pri_col;
    logic sec_valid;
    row_t sec_row;
    col_t sec_col;

    ps2_receiver #(
        .FRAME_TIMEOUT(FRAME_TIMEOUT)
    ) u_rx (
        .clk(clk),
        .rst_n(rst_n),
        .clkps2(clkps2),
        .dataps2(dataps2),
        .byte_valid(byte_valid),
        .rx_byte(rx_byte)
    );

    kbd_controller u_ctrl (
        .clk(clk),
        .rst_n(rst_n),
        .byte_valid(byte_valid),
        .rx_byte(rx_byte),
        .key_event(key_event),
        .key_code(key_code),
        .extended(extended),
        .released(released),
        .shift(shift),
        .ctrl(ctrl),
        .alt(alt),
        .clear_all(clear_all),
        .kbd_reset(kbd_reset),
        .kbd_nmi(kbd_nmi),
        .kbd_mreset(kbd_mreset)
    );

    key_translator u_xlat (
        .key_code(key_code),
        .extended(extended),
        .shift(shift),
        .ctrl(ctrl),
        .alt(alt),
        .pri_valid(pri_valid),
        .pri_row(pri_row),
        .pri_col(pri_col),
        .sec_valid(sec_valid),
        .sec_row(sec_row),
        .sec_col(sec_col)
    );

    key_matrix u_matrix (
        .clk(clk),
        .rst_n(rst_n),
        .key_event(key_event),
        .released(released),
        .clear_all(clear_all),
        .pri_valid(pri_valid),
        .pri_row(pri_row),
        .pri_col(pri_col),
        .sec_valid(sec_valid),
        .sec_row(sec_row),
        .sec_col(sec_col),
        .rows(rows),
        .columns(columns)
    );

endmodule

`default_nettype wire

// ==== tests/ps2_stim.svh ====
`ifndef PS2_STIM_SVH
`define PS2_STIM_SVH

////////////////////////////////////////////////////////////////////////////
// Keyboard side of the PS/2 link
////////////////////////////////////////////////////////////////////////////

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// Wait n rising edges, then step off the edge before driving
task automatic wait_clocks(input int n);
    repeat (n) @(posedge clk);
    #drive_dly;
endtask

// Start, 8 data bits LSB first, parity, stop
task automatic send_frame(input logic [7:0] data, input logic bad_parity);
    logic [10:0] bits;
    int b;
    bits = {1'b1, (~^data) ^ bad_parity, data, 1'b0};   // Odd parity unless corrupted
    wait_clocks(1);
    for (b = 0; b < 11; b++)
    begin
        dataps2 = bits[b];      // Changes while clkps2 is high
        wait_clocks(half_bit_cycles);
        clkps2 = 1'b0;
        wait_clocks(half_bit_cycles);
        clkps2 = 1'b1;
    end
endtask

// Quiet line between frames, 0 to 15 bit times
task automatic idle_gap();
    lcg_state = lcg_next(lcg_state);
    wait_clocks(1 + 2 * half_bit_cycles * int'(lcg_state[19:16]));
endtask

`endif

// ==== tests/tb_ace_keyboard.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ace_keyboard;

    localparam int clk_period = 100;
    localparam int drive_dly = 10;
    localparam int half_bit_cycles = 20;        // 40 clocks per PS/2 bit
    localparam logic [31:0] lcg_seed = 32'h010f99b1;
    localparam int num_entries = 36;
    // Three frames of 11 bits plus 16 idle bit times each, per entry
    localparam longint watchdog_ns = longint'(num_entries)
        * (3 * (11 + 16) * 2 * half_bit_cycles + 20) * clk_period + 300 * clk_period;

    logic clk;
    logic rst_n;
    logic clkps2;
    logic dataps2;
    logic [7:0] rows;
    wire [4:0] columns;
    wire kbd_reset;
    wire kbd_nmi;
    wire kbd_mreset;

    logic [31:0] lcg_state;

    int ent_count;
    int ent_nbytes [num_entries];
    logic [23:0] ent_bytes [num_entries];   // First byte sent is the highest used one
    logic ent_bad [num_entries];
    logic [7:0] ent_rows [num_entries];
    logic [4:0] ent_cols [num_entries];
    logic [2:0] ent_sys [num_entries];      // {kbd_reset, kbd_nmi, kbd_mreset}

    `include "ps2_stim.svh"

    ace_keyboard_top #(
        .FRAME_TIMEOUT(2000)
    ) UUT (
        .clk(clk),
        .rst_n(rst_n),
        .clkps2(clkps2),
        .dataps2(dataps2),
        .rows(rows),
        .columns(columns),
        .kbd_reset(kbd_reset),
        .kbd_nmi(kbd_nmi),
        .kbd_mreset(kbd_mreset)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic add_entry(input int n, input logic [23:0] bytes, input logic bad,
                             input logic [7:0] r, input logic [4:0] c, input logic [2:0] sys);
        ent_nbytes[ent_count] = n;
        ent_bytes[ent_count] = bytes;
        ent_bad[ent_count] = bad;
        ent_rows[ent_count] = r;
        ent_cols[ent_count] = c;
        ent_sys[ent_count] = sys;
        ent_count++;
    endtask

    task automatic check_value(input string what, input int idx,
                               input logic [7:0] expected, input logic [7:0] actual);
        assert (actual === expected)
        else
        begin
            $display("ERR %0t: entry %0d %s expected %h got %h",
                     $time, idx, what, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Output mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Frames to send, row scan, expected columns and system lines
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_table();
        add_entry(0, 24'h000000, 0, 8'h00, 5'h1f, 3'b111);  // Idle after reset
        add_entry(1, 24'h00001c, 0, 8'hfd, 5'h1e, 3'b111);  // A in row 1
        add_entry(0, 24'h000000, 0, 8'hfe, 5'h1f, 3'b111);
        add_entry(2, 24'h00f01c, 0, 8'hfd, 5'h1f, 3'b111);
        add_entry(2, 24'h00121c, 0, 8'hfe, 5'h1e, 3'b111);  // Shift+A
        add_entry(0, 24'h000000, 0, 8'hfd, 5'h1e, 3'b111);
        add_entry(2, 24'h00f01c, 0, 8'hfc, 5'h1f, 3'b111);
        add_entry(1, 24'h00001e, 0, 8'hdf, 5'h1e, 3'b111);  // Shift+2
        add_entry(0, 24'h000000, 0, 8'hfe, 5'h1d, 3'b111);
        add_entry(2, 24'h00f01e, 0, 8'hde, 5'h1f, 3'b111);
        add_entry(2, 24'h00f012, 0, 8'h00, 5'h1f, 3'b111);
        add_entry(2, 24'h001116, 0, 8'hfd, 5'h1d, 3'b111);  // Alt+1
        add_entry(0, 24'h000000, 0, 8'hfe, 5'h1d, 3'b111);
        add_entry(2, 24'h00f016, 0, 8'hfc, 5'h1f, 3'b111);
        add_entry(2, 24'h00f011, 0, 8'h00, 5'h1f, 3'b111);
        add_entry(2, 24'h00e014, 0, 8'hfe, 5'h1d, 3'b111);  // Right control
        add_entry(1, 24'h000014, 0, 8'hfe, 5'h1c, 3'b111);  // Plus left control
        add_entry(3, 24'he0f014, 0, 8'hfe, 5'h1e, 3'b111);
        add_entry(2, 24'h00f014, 0, 8'hfe, 5'h1f, 3'b111);
        add_entry(2, 24'h00e075, 0, 8'hef, 5'h0f, 3'b111);  // Cursor up
        add_entry(0, 24'h000000, 0, 8'hee, 5'h0e, 3'b111);  // Rows 0 and 4 together
        add_entry(3, 24'he0f075, 0, 8'h00, 5'h1f, 3'b111);
        add_entry(3, 24'h141103, 0, 8'h00, 5'h1e, 3'b101);  // Ctrl, alt, F5
        add_entry(2, 24'h00f003, 0, 8'h00, 5'h1e, 3'b111);
        add_entry(1, 24'h000066, 0, 8'h00, 5'h1e, 3'b110);  // Backspace
        add_entry(2, 24'h00f066, 0, 8'h00, 5'h1e, 3'b111);
        add_entry(1, 24'h00001c, 0, 8'hfd, 5'h1e, 3'b111);
        add_entry(1, 24'h000071, 0, 8'h00, 5'h1f, 3'b011);  // Keypad period clears all
        add_entry(2, 24'h00f071, 0, 8'h00, 5'h1f, 3'b111);
        add_entry(2, 24'h00f011, 0, 8'h00, 5'h1f, 3'b111);
        add_entry(2, 24'h00f014, 0, 8'h00, 5'h1f, 3'b111);
        add_entry(1, 24'h000032, 0, 8'h7f, 5'h17, 3'b111);  // B held as a marker
        add_entry(1, 24'h00001c, 1, 8'h00, 5'h17, 3'b111);  // Bad parity
        add_entry(2, 24'h00f02b, 0, 8'hfd, 5'h1f, 3'b111);  // Release of F never pressed
        add_entry(1, 24'h00004e, 0, 8'h00, 5'h17, 3'b111);  // Not a kept key
        add_entry(2, 24'h00f032, 0, 8'h00, 5'h1f, 3'b111);
    endtask

    initial
    begin
        int i;
        int k;
        clkps2 = 1'b1;
        dataps2 = 1'b1;
        rows = 8'hff;
        rst_n = 1'b0;
        lcg_state = lcg_seed;
        ent_count = 0;
        load_table();
        repeat (4) @(posedge clk);
        #drive_dly;
        rst_n = 1'b1;

        // Empty matrix answers every scan with all columns high
        repeat (8)
        begin
            wait_clocks(1);
            lcg_state = lcg_next(lcg_state);
            rows = lcg_state[23:16];
            @(negedge clk);
            check_value("columns after reset", -1, 8'h1f, {3'b000, columns});
        end

        for (i = 0; i < ent_count; i++)
        begin
            for (k = ent_nbytes[i] - 1; k >= 0; k--)
            begin
                send_frame(ent_bytes[i][8*k +: 8], ent_bad[i]);
                idle_gap();
            end
            wait_clocks(10);
            rows = ent_rows[i];
            @(posedge clk);
            @(negedge clk);
            check_value("columns", i, {3'b000, ent_cols[i]}, {3'b000, columns});
            check_value("kbd_reset", i, {7'd0, ent_sys[i][2]}, {7'd0, kbd_reset});
            check_value("kbd_nmi", i, {7'd0, ent_sys[i][1]}, {7'd0, kbd_nmi});
            check_value("kbd_mreset", i, {7'd0, ent_sys[i][0]}, {7'd0, kbd_mreset});
        end

        $display("Simulation passed");
        $finish;
    end

    initial
    begin
        #(watchdog_ns);
        $display("Simulation failed");
        $fatal(1, "Timeout: the run timed out and the stimulus never finished");
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+tests
src/ace_kbd_pkg.sv
src/ps2_receiver.sv
src/kbd_controller.sv
src/key_translator.sv
src/key_matrix.sv
src/ace_keyboard_top.sv
tests/tb_ace_keyboard.sv
